// File: design/sha_pad_pkg.sv
package sha_pad_pkg;

  // ------------------------------
  // block geometry
  // ------------------------------

  // message words arrive 32 bits at a time
  localparam int word_w = 32;

  // one SHA-512 message block
  localparam int block_w = 1024;
  localparam int block_bytes = block_w / 8;
  localparam int words_per_block = block_w / word_w;

  // ------------------------------
  // length handling
  // ------------------------------

  // the bit length of the message sits in the low 128 bits of the final block
  localparam int len_field_w = 128;

  // running byte count of one message
  localparam int msg_len_w = 32;

  // a last block with at most this many data bytes still has room
  // for the 0x80 marker byte and the length field
  localparam int len_fit_max = block_bytes - len_field_w / 8 - 1;

  // description of one assembled block, travels beside the block data
  typedef struct packed {
    // valid data bytes in this block, 1 to 128
    logic [7:0]           num_bytes;
    // last block of the message
    logic                 is_last;
    // first block of the message, the core starts a new hash on it
    logic                 is_first;
    // total message length in bytes up to and including this block
    logic [msg_len_w-1:0] msg_bytes;
  } block_info_t;

endpackage

// File: design/sha_block_if.sv
interface sha_block_if;

  // ------------------------------
  // block handoff between stages
  // ------------------------------

  // a block moves on a rising edge where valid and ready are both high,
  // valid and the payload hold steady until then
  logic                            valid;
  logic                            ready;
  logic [sha_pad_pkg::block_w-1:0] data;
  sha_pad_pkg::block_info_t        info;

  // the stage that assembles a block
  modport src (
    output valid,
    output data,
    output info,
    input  ready
  );

  // the stage that consumes a block
  modport dst (
    input  valid,
    input  data,
    input  info,
    output ready
  );

endinterface

// File: design/sha_block_packer.sv
module sha_block_packer #(
  parameter int word_width = sha_pad_pkg::word_w
) (
  input  logic                  clk,
  input  logic                  rst_b,
  input  logic                  word_valid,
  output logic                  word_ready,
  input  logic [word_width-1:0] word_data,
  input  logic [2:0]            word_bytes,
  input  logic                  word_last,
  input  logic                  word_swap,
  sha_block_if.src              blk
);

  localparam int bytes_per_word = word_width / 8;
  localparam int words_per_block = sha_pad_pkg::block_w / word_width;
  localparam int ptr_w = $clog2(words_per_block);

  logic                                 valid_q;
  logic [0:words_per_block-1][word_width-1:0] block_q;
  sha_pad_pkg::block_info_t             info_q;
  logic [ptr_w-1:0]                     word_ptr;
  logic [sha_pad_pkg::msg_len_w-1:0]    msg_count;
  logic                                 first_q;

  logic                  accept;
  logic                  block_done;
  logic                  blk_xfer;
  logic [word_width-1:0] swapped;
  logic [word_width-1:0] wdata;
  logic [7:0]            add_bytes;
  logic [7:0]            blk_bytes;
  logic [sha_pad_pkg::msg_len_w-1:0] count_nxt;

  // ------------------------------
  // word intake
  // ------------------------------

  // a held block blocks the source until the padder takes it
  assign word_ready = ~valid_q;
  assign accept = word_valid & word_ready;
  assign blk_xfer = valid_q & blk.ready;

  // with swap set the least significant byte is the first message byte,
  // so reverse the lanes to keep the block big-endian
  always_comb begin
    for (int b = 0; b < bytes_per_word; b++) begin
      swapped[b*8 +: 8] = word_data[(bytes_per_word-1-b)*8 +: 8];
    end
  end

  assign wdata = word_swap ? swapped : word_data;

  // only the last word of a message may be partial
  assign add_bytes = word_last ? 8'(word_bytes) : 8'(bytes_per_word);
  assign count_nxt = msg_count + sha_pad_pkg::msg_len_w'(add_bytes);

  // data bytes held once this word is in, full slots ahead of it plus this one
  assign blk_bytes = 8'(word_ptr) * 8'(bytes_per_word) + add_bytes;

  // the block closes on its last slot or on the end of the message
  assign block_done = accept & (word_last | (word_ptr == ptr_w'(words_per_block - 1)));

  // ------------------------------
  // control state
  // ------------------------------

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      valid_q <= 1'b0;
      word_ptr <= '0;
      msg_count <= '0;
      first_q <= 1'b1;
    end else begin
      if (accept) begin
        msg_count <= count_nxt;
        word_ptr <= block_done ? '0 : word_ptr + 1'b1;
      end
      if (block_done) begin
        valid_q <= 1'b1;
      end else if (blk_xfer) begin
        valid_q <= 1'b0;
        // after the last block the next word starts a fresh message
        first_q <= info_q.is_last;
        if (info_q.is_last) begin
          msg_count <= '0;
        end
      end
    end
  end

  // ------------------------------
  // block payload
  // ------------------------------

  // lanes past the end of a short message keep old bytes, the padder masks them
  always_ff @(posedge clk) begin
    if (accept) begin
      block_q[word_ptr] <= wdata;
    end
    if (block_done) begin
      info_q.num_bytes <= blk_bytes;
      info_q.is_last <= word_last;
      info_q.is_first <= first_q;
      info_q.msg_bytes <= count_nxt;
    end
  end

  assign blk.valid = valid_q;
  assign blk.data = block_q;
  assign blk.info = info_q;

endmodule

// File: design/sha_block_padder.sv
module sha_block_padder #(
  parameter int word_width = sha_pad_pkg::word_w
) (
  input  logic                            clk,
  input  logic                            rst_b,
  sha_block_if.dst                        blk,
  output logic                            block_valid,
  input  logic                            block_ready,
  output logic [sha_pad_pkg::block_w-1:0] block_data,
  output logic                            block_first,
  output logic                            block_final
);

  localparam int bytes_per_word = word_width / 8;
  localparam int words_per_block = sha_pad_pkg::block_w / word_width;
  localparam int block_bytes = sha_pad_pkg::block_bytes;
  localparam int len_bytes = sha_pad_pkg::len_field_w / 8;
  // first byte of the length field at the tail of a block
  localparam int len_byte0 = block_bytes - len_bytes;
  localparam int idx_w = $clog2(block_bytes);

  // byte view of a block, byte 0 is the most significant
  typedef logic [0:block_bytes-1][7:0] block_bytes_t;

  block_bytes_t pad_bytes;
  block_bytes_t extra_bytes;
  logic [7:0]   n;
  logic         len_fits;
  logic         need_extra;
  logic         take;
  logic         send;

  // extra block still to be sent after the current output
  logic                              pend_q;
  logic [sha_pad_pkg::msg_len_w-1:0] pend_len;
  logic                              pend_pad80;

  // message length in bits, right aligned in the length field
  function automatic logic [sha_pad_pkg::len_field_w-1:0] len_field(
    input logic [sha_pad_pkg::msg_len_w-1:0] nbytes
  );
    return sha_pad_pkg::len_field_w'(nbytes) << 3;
  endfunction

  // ------------------------------
  // handshakes
  // ------------------------------

  // accept a new block only when nothing is held or owed downstream
  assign blk.ready = ~block_valid & ~pend_q;
  assign take = blk.valid & blk.ready;
  assign send = block_valid & block_ready;

  assign n = blk.info.num_bytes;
  assign len_fits = (n <= 8'(sha_pad_pkg::len_fit_max));
  assign need_extra = blk.info.is_last & ~len_fits;

  // ------------------------------
  // padding of the incoming block
  // ------------------------------

  always_comb begin
    pad_bytes = blk.data;
    // clear every byte lane behind the message data, word by word
    for (int w = 0; w < words_per_block; w++) begin
      for (int b = 0; b < bytes_per_word; b++) begin
        if (w * bytes_per_word + b >= int'(n)) begin
          pad_bytes[w*bytes_per_word + b] = 8'h00;
        end
      end
    end
    // marker byte right after the data when there is space for it
    if (n < 8'(block_bytes)) begin
      pad_bytes[n[idx_w-1:0]] = 8'h80;
    end
    if (len_fits) begin
      pad_bytes[len_byte0 +: len_bytes] = len_field(blk.info.msg_bytes);
    end
    // blocks in the middle of a message go through as they are
    if (!blk.info.is_last) begin
      pad_bytes = blk.data;
    end
  end

  // the trailing block is zero apart from the length, and it carries the
  // marker byte too when the data ended on a block boundary
  always_comb begin
    extra_bytes = '0;
    if (pend_pad80) begin
      extra_bytes[0] = 8'h80;
    end
    extra_bytes[len_byte0 +: len_bytes] = len_field(pend_len);
  end

  // ------------------------------
  // output register
  // ------------------------------

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      block_valid <= 1'b0;
      pend_q <= 1'b0;
    end else if (take) begin
      block_valid <= 1'b1;
      pend_q <= need_extra;
    end else if (send) begin
      // an owed extra block follows straight after, otherwise go empty
      block_valid <= pend_q;
      pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      block_data <= pad_bytes;
      block_first <= blk.info.is_first;
      block_final <= blk.info.is_last & len_fits;
      pend_len <= blk.info.msg_bytes;
      pend_pad80 <= (n == 8'(block_bytes));
    end else if (send && pend_q) begin
      block_data <= extra_bytes;
      block_first <= 1'b0;
      block_final <= 1'b1;
    end
  end

endmodule

// File: design/sha_pad_top.sv
module sha_pad_top #(
  parameter int word_width = sha_pad_pkg::word_w
) (
  input  logic                            clk,
  input  logic                            rst_b,

  // message words from the source
  input  logic                            word_valid,
  output logic                            word_ready,
  input  logic [word_width-1:0]           word_data,
  input  logic [2:0]                      word_bytes,
  input  logic                            word_last,
  input  logic                            word_swap,

  // padded blocks toward the hash core
  output logic                            block_valid,
  input  logic                            block_ready,
  output logic [sha_pad_pkg::block_w-1:0] block_data,
  output logic                            block_first,
  output logic                            block_final
);

  // ------------------------------
  // two stage front end
  // ------------------------------

  // raw assembled blocks from the packer to the padder
  sha_block_if blk_if ();

  // words in, raw blocks with their byte counts out
  sha_block_packer #(
    .word_width (word_width)
  ) u_packer (
    .clk        (clk),
    .rst_b      (rst_b),
    .word_valid (word_valid),
    .word_ready (word_ready),
    .word_data  (word_data),
    .word_bytes (word_bytes),
    .word_last  (word_last),
    .word_swap  (word_swap),
    .blk        (blk_if.src)
  );

  // raw blocks in, padded and tagged blocks out
  sha_block_padder #(
    .word_width (word_width)
  ) u_padder (
    .clk         (clk),
    .rst_b       (rst_b),
    .blk         (blk_if.dst),
    .block_valid (block_valid),
    .block_ready (block_ready),
    .block_data  (block_data),
    .block_first (block_first),
    .block_final (block_final)
  );

endmodule

// File: dv/sha_pad_tb.sv
module sha_pad_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam string stim_file = "dv/sha_pad_stimulus.txt";
  localparam int word_wait_max = 2000;
  localparam int block_wait_max = 2000;
  localparam int bpw = sha_pad_pkg::word_w / 8;
  localparam int bw = sha_pad_pkg::block_w;

  logic                               clk;
  logic                               rst_b;
  logic                               word_valid;
  logic                               word_ready;
  logic [sha_pad_pkg::word_w-1:0]     word_data;
  logic [2:0]                         word_bytes;
  logic                               word_last;
  logic                               word_swap;
  logic                               block_valid;
  logic                               block_ready;
  logic [bw-1:0]                      block_data;
  logic                               block_first;
  logic                               block_final;

  // message descriptions, one entry per message line of the stimulus file
  int msg_swap[$];
  int msg_len[$];
  int msg_seed[$];
  int msg_step[$];
  int msg_nblk[$];
  // expected blocks of all messages, in the order they must come out
  logic [bw-1:0] exp_data[$];
  logic          exp_first[$];
  logic          exp_final[$];

  sha_pad_top #(
    .word_width (sha_pad_pkg::word_w)
  ) dut (.*);

  always #20 clk = ~clk;

  // ------------------------------
  // helpers
  // ------------------------------

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_block(input string name, input logic [bw-1:0] got,
                             input logic [bw-1:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAIL %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAIL %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      stop_with_failure($sformatf("FAIL %s: got %h expected %h", name, got, exp));
    end
  endtask

  // every byte of a message follows from its position
  function automatic logic [7:0] msg_byte(input int m, input int pos);
    return 8'(msg_seed[m] + msg_step[m] * pos);
  endfunction

  // ------------------------------
  // stimulus file
  // ------------------------------

  task automatic read_stimulus();
    int fd;
    string line;
    int sw, len, seed, step, bf, bl, m, k, pos;
    logic [sha_pad_pkg::len_field_w-1:0] lbits;
    logic [bw-1:0] blk;
    fd = $fopen(stim_file, "r");
    if (fd == 0) begin
      stop_with_failure("the stimulus file could not be opened");
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      if ($sscanf(line, "m %d %d %h %h", sw, len, seed, step) == 4) begin
        msg_swap.push_back(sw);
        msg_len.push_back(len);
        msg_seed.push_back(seed);
        msg_step.push_back(step);
        msg_nblk.push_back(0);
      end else if ($sscanf(line, "b %d %d %h", bf, bl, lbits) == 3) begin
        m = msg_len.size() - 1;
        k = msg_nblk[m];
        // padded message: data bytes, one 0x80 byte, then zeros
        blk = '0;
        for (int j = 0; j < sha_pad_pkg::block_bytes; j++) begin
          pos = k * sha_pad_pkg::block_bytes + j;
          if (pos < msg_len[m]) blk[bw-1-8*j -: 8] = msg_byte(m, pos);
          else if (pos == msg_len[m]) blk[bw-1-8*j -: 8] = 8'h80;
        end
        // the bit length closes the final block
        if (bl != 0) blk[sha_pad_pkg::len_field_w-1:0] = lbits;
        exp_data.push_back(blk);
        exp_first.push_back(bf != 0);
        exp_final.push_back(bl != 0);
        msg_nblk[m] = k + 1;
      end
    end
    $fclose(fd);
    if (exp_data.size() == 0) begin
      stop_with_failure("the stimulus file holds no expected blocks");
    end
  endtask

  // ------------------------------
  // word source and block sink
  // ------------------------------

  task automatic send_messages();
    logic [sha_pad_pkg::word_w-1:0] data;
    logic [7:0] b;
    int nwords, pos, waited;
    for (int m = 0; m < msg_len.size(); m++) begin
      nwords = (msg_len[m] + bpw - 1) / bpw;
      for (int w = 0; w < nwords; w++) begin
        for (int l = 0; l < bpw; l++) begin
          pos = w * bpw + l;
          // lanes past the message end carry junk, the padder has to mask it
          b = (pos < msg_len[m]) ? msg_byte(m, pos) : 8'($urandom);
          if (msg_swap[m] != 0) data[8*l +: 8] = b;
          else data[sha_pad_pkg::word_w-8-8*l +: 8] = b;
        end
        word_valid <= 1'b1;
        word_data <= data;
        word_last <= (w == nwords - 1);
        word_bytes <= (w == nwords - 1) ? 3'(msg_len[m] - w * bpw) : 3'(bpw);
        word_swap <= (msg_swap[m] != 0);
        waited = 0;
        do begin
          @(posedge clk);
          waited++;
          if (waited > word_wait_max) begin
            stop_with_failure("timeout: word_ready stayed low while a word was offered");
          end
        end while (!word_ready);
      end
    end
    word_valid <= 1'b0;
  endtask

  task automatic collect_blocks();
    int waited, m, got_cnt;
    logic got;
    m = 0;
    got_cnt = 0;
    for (int k = 0; k < exp_data.size(); k++) begin
      waited = 0;
      got = 1'b0;
      while (!got) begin
        @(posedge clk);
        got = block_valid && block_ready;
        // the sink stalls about a third of the cycles
        block_ready <= ($urandom % 3) != 0;
        waited++;
        if (!got && waited > block_wait_max) begin
          stop_with_failure("timeout: no padded block arrived when one was expected");
        end
      end
      got_cnt++;
      // a final block closes its message, which by then must have produced
      // every one of its blocks
      if (block_final) begin
        check_count("blocks per message", got_cnt, msg_nblk[m]);
        m++;
        got_cnt = 0;
      end
      check_block("block_data", block_data, exp_data[k]);
      check_flag("block_first", block_first, exp_first[k]);
      check_flag("block_final", block_final, exp_final[k]);
    end
  endtask

  // ------------------------------
  // run
  // ------------------------------

  initial begin
    void'($urandom(71787));
    clk = 1'b0;
    rst_b = 1'b0;
    word_valid = 1'b0;
    word_data = '0;
    word_bytes = '0;
    word_last = 1'b0;
    word_swap = 1'b0;
    block_ready = 1'b0;
    read_stimulus();
    repeat (8) @(posedge clk);
    rst_b <= 1'b1;
    fork
      send_messages();
      collect_blocks();
    join
    // a block after the last expected one means something was duplicated
    repeat (20) begin
      @(posedge clk);
      if (block_valid) begin
        stop_with_failure("a block came out after the last expected block");
      end
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: all.f
design/sha_pad_pkg.sv
design/sha_block_if.sv
design/sha_block_packer.sv
design/sha_block_padder.sv
design/sha_pad_top.sv
dv/sha_pad_tb.sv

// File: dv/sha_pad_stimulus.txt
# m <swap> <length in bytes, decimal> <first byte, hex> <byte step, hex>
#   message byte i is first + i * step, modulo 256
# b <first> <final> <bit length, hex>, one line per expected block
#   the bit length only lands in the low 128 bits of a final block
m 0 5 3c 01
b 1 1 28
m 1 3 a0 03
b 1 1 18
m 0 111 11 05
b 1 1 378
m 1 112 22 07
b 1 0 0
b 0 1 380
m 0 127 5a 0b
b 1 0 0
b 0 1 3f8
m 0 128 00 01
b 1 0 0
b 0 1 400
m 1 256 7f 0d
b 1 0 0
b 0 0 0
b 0 1 800
m 0 200 c3 13
b 1 0 0
b 0 1 640
m 1 245 e1 1f
b 1 0 0
b 0 0 0
b 0 1 7a8
m 0 1 ff 01
b 1 1 8
